//--- common/dc_defines.svh
`ifndef DC_DEFINES_SVH
`define DC_DEFINES_SVH

// main memory address, also cursor and top width.
`define DC_ADDR_WIDTH 8

// one memory word.
`define DC_DATA_WIDTH 16

// words in main memory, full address range.
`define DC_MEM_DEPTH 256

`endif

//--- common/dc_pkg.sv
`include "dc_defines.svh"

package dc_pkg;

  // opcode field, instruction[7:2].
  typedef enum logic [5:0] {
    OP_READZ  = 6'd1,
    OP_WRITEZ = 6'd2,
    OP_SETFZ  = 6'd3,
    OP_SETBZ  = 6'd4
  } dc_op_e;

  // complete cursor state of the unit.
  typedef struct packed {
    logic [3:0][`DC_ADDR_WIDTH-1:0] addr;
    logic [3:0]                     dir;      // set means backward.
    logic [3:0]                     modified;
  } dc_state_s;

  // one request toward main memory.
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`DC_ADDR_WIDTH-1:0] addr;
    logic [`DC_DATA_WIDTH-1:0] wdata;
  } mem_req_s;

  // prefetched word per cursor.
  typedef logic [3:0][`DC_DATA_WIDTH-1:0] dc_values_s;

endpackage

//--- dc/dc_control.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module dc_control (
  input  logic [7:0]                instruction,
  input  logic                      jump_immediate,
  input  logic [`DC_ADDR_WIDTH-1:0] top,
  input  dc_pkg::dc_state_s         cur,
  output dc_pkg::dc_state_s         nxt,
  output logic                      write_out,
  output logic [`DC_ADDR_WIDTH-1:0] write_address,
  output logic                      reload,
  output logic [1:0]                choice
);

  dc_pkg::dc_op_e                   op;
  logic [1:0]                       sel;
  logic [3:0][`DC_ADDR_WIDTH-1:0]   read_adv;
  logic [3:0][`DC_ADDR_WIDTH-1:0]   write_adv;

  assign op  = dc_pkg::dc_op_e'(instruction[7:2]);
  assign sel = instruction[1:0];

  // all cursors advance in parallel, the mux picks one.
  for (genvar i = 0; i < 4; i++) begin : g_adv
    assign read_adv[i]  = cur.addr[i] + 1'b1;
    assign write_adv[i] = cur.dir[i] ? cur.addr[i] - 1'b1 : cur.addr[i] + 1'b1;
  end

  always_comb begin
    nxt           = cur;
    write_out     = 1'b0;
    write_address = '0;
    reload        = 1'b0;
    choice        = sel;
    case (op)
      dc_pkg::OP_READZ: begin
        nxt.addr[sel] = read_adv[sel];
        reload        = 1'b1;
      end
      dc_pkg::OP_WRITEZ: begin
        nxt.addr[sel] = write_adv[sel];
        write_out     = 1'b1;
        // backward cursors step first, then write.
        write_address = cur.dir[sel] ? write_adv[sel] : cur.addr[sel];
        reload        = 1'b1;
      end
      dc_pkg::OP_SETFZ: begin
        nxt.addr[sel]     = top;
        nxt.dir[sel]      = 1'b0;
        nxt.modified[sel] = 1'b1;
        reload            = 1'b1;
      end
      dc_pkg::OP_SETBZ: begin
        nxt.addr[sel]     = top;
        nxt.dir[sel]      = 1'b1;
        nxt.modified[sel] = 1'b1;
        reload            = 1'b1;
      end
      default: begin
        if (jump_immediate) begin // implicit read on cursor 0.
          choice      = 2'd0;
          nxt.addr[0] = read_adv[0];
          reload      = 1'b1;
        end
      end
    endcase
  end

endmodule

//--- dc/dc_state.sv
`timescale 1ns/1ps

module dc_state (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_strobe,
  input  logic              busy,
  input  dc_pkg::dc_state_s nxt,
  input  logic              reload,
  input  logic [1:0]        choice,
  output dc_pkg::dc_state_s state,
  output logic              accept,
  output logic              load_pulse,
  output logic [1:0]        load_choice
);

  // strobes during a reload are dropped.
  assign accept = instr_strobe & ~busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= '0;
    end else if (accept) begin
      state <= nxt;
    end
  end

  // reload request goes out one cycle after acceptance.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_pulse  <= 1'b0;
      load_choice <= 2'd0;
    end else begin
      load_pulse <= accept & reload;
      if (accept) begin
        load_choice <= choice;
      end
    end
  end

endmodule

//--- dc/dc_prefetch.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module dc_prefetch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load_pulse,
  input  logic [1:0]                load_choice,
  input  dc_pkg::dc_state_s         state,
  input  logic                      grant,
  input  logic [`DC_DATA_WIDTH-1:0] rdata,
  input  logic                      rvalid,
  output dc_pkg::mem_req_s          req,
  output dc_pkg::dc_values_s        values,
  output logic                      busy
);

  typedef enum logic [1:0] {
    PF_IDLE,
    PF_REQ,
    PF_WAIT
  } pf_state_e;

  pf_state_e  pf_st;
  logic [1:0] slot;

  // load_pulse covers the first cycle before the FSM leaves idle.
  assign busy = (pf_st != PF_IDLE) | load_pulse;

  // address is stable, the cursor cannot change while busy.
  always_comb begin
    req       = '0;
    req.req   = (pf_st == PF_REQ);
    req.addr  = state.addr[slot];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pf_st  <= PF_IDLE;
      slot   <= 2'd0;
      values <= '0;
    end else begin
      case (pf_st)
        PF_IDLE: begin
          if (load_pulse) begin
            slot  <= load_choice;
            pf_st <= PF_REQ;
          end
        end
        PF_REQ: begin
          if (grant) pf_st <= PF_WAIT;
        end
        PF_WAIT: begin
          if (rvalid) begin
            values[slot] <= rdata;
            pf_st        <= PF_IDLE;
          end
        end
        default: pf_st <= PF_IDLE;
      endcase
    end
  end

endmodule

//--- dc/dc_writer.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module dc_writer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      accept,
  input  logic                      write_out,
  input  logic [`DC_ADDR_WIDTH-1:0] write_address,
  input  logic [`DC_DATA_WIDTH-1:0] write_data,
  input  logic                      grant,
  output dc_pkg::mem_req_s          req
);

  logic                      pending;
  logic [`DC_ADDR_WIDTH-1:0] addr_q;
  logic [`DC_DATA_WIDTH-1:0] data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (accept && write_out) begin
      pending <= 1'b1;
    end else if (grant) begin
      pending <= 1'b0; // one grant retires the write.
    end
  end

  always_ff @(posedge clk) begin
    if (accept && write_out) begin
      addr_q <= write_address;
      data_q <= write_data;
    end
  end

  assign req = '{req: pending, we: 1'b1, addr: addr_q, wdata: data_q};

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic             clk,
  input  logic             rst_n,
  input  dc_pkg::mem_req_s wr_req,
  input  dc_pkg::mem_req_s rd_req,
  output logic             wr_grant,
  output logic             rd_grant,
  output dc_pkg::mem_req_s mem,
  output logic             rvalid
);

  logic rd_owned; // prefetcher owns the read in flight.

  // writer always first.
  assign wr_grant = wr_req.req;
  assign rd_grant = rd_req.req & ~wr_req.req;

  always_comb begin
    if (wr_grant) begin
      mem = wr_req;
    end else if (rd_grant) begin
      mem = rd_req;
    end else begin
      mem = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_owned <= 1'b0;
    end else begin
      rd_owned <= rd_grant & ~rd_req.we;
    end
  end

  assign rvalid = rd_owned;  // ram data lands with this.

endmodule

//--- verilog/main_ram.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module main_ram (
  input  logic                      clk,
  input  dc_pkg::mem_req_s          mem,
  output logic [`DC_DATA_WIDTH-1:0] rdata
);

  logic [`DC_DATA_WIDTH-1:0] ram [`DC_MEM_DEPTH];

  // contents start at zero.
  initial begin
    for (int i = 0; i < `DC_MEM_DEPTH; i++) begin
      ram[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        ram[mem.addr] <= mem.wdata;
      end else begin
        rdata <= ram[mem.addr]; // one cycle latency.
      end
    end
  end

endmodule

//--- verilog/dc_unit.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module dc_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_strobe,
  input  logic [7:0]                instruction,
  input  logic                      jump_immediate,
  input  logic [`DC_ADDR_WIDTH-1:0] top,
  input  logic [`DC_DATA_WIDTH-1:0] write_data,
  output dc_pkg::dc_state_s         state,
  output dc_pkg::dc_values_s        values,
  output logic                      busy
);

  dc_pkg::dc_state_s         nxt;
  logic                      write_out;
  logic [`DC_ADDR_WIDTH-1:0] write_address;
  logic                      reload;
  logic [1:0]                choice;
  logic                      accept;
  logic                      load_pulse;
  logic [1:0]                load_choice;
  dc_pkg::mem_req_s          wr_req;
  dc_pkg::mem_req_s          rd_req;
  dc_pkg::mem_req_s          mem;
  logic                      wr_grant;
  logic                      rd_grant;
  logic                      rvalid;
  logic [`DC_DATA_WIDTH-1:0] rdata;

  dc_control u_control (
    .instruction(instruction), .jump_immediate(jump_immediate), .top(top),
    .cur(state), .nxt(nxt), .write_out(write_out), .write_address(write_address),
    .reload(reload), .choice(choice)
  );

  dc_state u_state (
    .clk(clk), .rst_n(rst_n), .instr_strobe(instr_strobe), .busy(busy), .nxt(nxt),
    .reload(reload), .choice(choice), .state(state), .accept(accept),
    .load_pulse(load_pulse), .load_choice(load_choice)
  );

  dc_writer u_writer (
    .clk(clk), .rst_n(rst_n), .accept(accept), .write_out(write_out),
    .write_address(write_address), .write_data(write_data), .grant(wr_grant),
    .req(wr_req)
  );

  dc_prefetch u_prefetch (
    .clk(clk), .rst_n(rst_n), .load_pulse(load_pulse), .load_choice(load_choice),
    .state(state), .grant(rd_grant), .rdata(rdata), .rvalid(rvalid), .req(rd_req),
    .values(values), .busy(busy)
  );

  mem_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n), .wr_req(wr_req), .rd_req(rd_req), .wr_grant(wr_grant),
    .rd_grant(rd_grant), .mem(mem), .rvalid(rvalid)
  );

  main_ram u_ram (.clk(clk), .mem(mem), .rdata(rdata));

endmodule

//--- tb/dc_unit_assert.sv
`timescale 1ns/1ps

module dc_unit_assert (
  input logic             clk,
  input logic             rst_n,
  input dc_pkg::mem_req_s rd_req,
  input logic             wr_grant,
  input logic             rd_grant,
  input logic             busy
);

  logic [4:0] busy_cycles;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_cycles <= 5'd0;
    end else if (!busy) begin
      busy_cycles <= 5'd0;
    end else if (busy_cycles != 5'd31) begin
      busy_cycles <= busy_cycles + 5'd1; // saturates.
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_grant && rd_grant)) else $error("both memory grants high");

  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req.req && !rd_grant |=> rd_req.req && $stable(rd_req.addr))
    else $error("read request changed before its grant");

  // a reload needs only a handful of cycles.
  a_busy_bound: assert property (@(posedge clk) disable iff (!rst_n)
    busy_cycles < 5'd12) else $error("busy held too long");

endmodule

bind dc_unit dc_unit_assert u_assert (
  .clk(clk), .rst_n(rst_n), .rd_req(rd_req),
  .wr_grant(wr_grant), .rd_grant(rd_grant), .busy(busy)
);

//--- tb/dc_unit_tb.sv
`timescale 1ns/1ps
`include "dc_defines.svh"

module dc_unit_tb;

  localparam int num_directed = 16;
  localparam int num_random   = 2000;
  // twenty cycles per instruction, plus reset and slack.
  localparam int watchdog_cycles = (num_directed + num_random) * 20 + 100;

  logic                      clk;
  logic                      rst_n;
  logic                      instr_strobe;
  logic [7:0]                instruction;
  logic                      jump_immediate;
  logic [`DC_ADDR_WIDTH-1:0] top;
  logic [`DC_DATA_WIDTH-1:0] write_data;
  dc_pkg::dc_state_s         state;
  dc_pkg::dc_values_s        values;
  logic                      busy;

  // reference model.
  logic [`DC_DATA_WIDTH-1:0] m_mem [`DC_MEM_DEPTH];
  logic [`DC_ADDR_WIDTH-1:0] m_addr [4];
  logic [3:0]                m_dir;
  logic [3:0]                m_mod;
  logic [`DC_DATA_WIDTH-1:0] m_val [4];
  logic [15:0]               lfsr;

  dc_unit dut0 (
    .clk(clk), .rst_n(rst_n), .instr_strobe(instr_strobe), .instruction(instruction),
    .jump_immediate(jump_immediate), .top(top), .write_data(write_data),
    .state(state), .values(values), .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * 8);
    $display("run timed out, an instruction never finished");
    report_failure();
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_state(input dc_pkg::dc_state_s got, input dc_pkg::dc_state_s exp);
    if (got !== exp) begin
      $display("FAILED state got %h expected %h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_values(input dc_pkg::dc_values_s got, input dc_pkg::dc_values_s exp);
    if (got !== exp) begin
      $display("FAILED values got %h expected %h", got, exp);
      report_failure();
    end
  endtask

  function automatic dc_pkg::dc_state_s expected_state();
    dc_pkg::dc_state_s s;
    for (int i = 0; i < 4; i++) begin
      s.addr[i]     = m_addr[i];
      s.dir[i]      = m_dir[i];
      s.modified[i] = m_mod[i];
    end
    return s;
  endfunction

  function automatic dc_pkg::dc_values_s expected_values();
    dc_pkg::dc_values_s v;
    for (int i = 0; i < 4; i++) begin
      v[i] = m_val[i];
    end
    return v;
  endfunction

  task automatic model_apply(input logic [5:0] op, input logic [1:0] c, input logic ji,
                             input logic [7:0] t, input logic [15:0] wd, output logic reload);
    logic [1:0] sel;
    sel    = c;
    reload = 1'b1;
    case (op)
      dc_pkg::OP_READZ: m_addr[c] = m_addr[c] + 8'd1;
      dc_pkg::OP_WRITEZ: begin
        if (m_dir[c]) begin // step back, then write.
          m_addr[c]        = m_addr[c] - 8'd1;
          m_mem[m_addr[c]] = wd;
        end else begin
          m_mem[m_addr[c]] = wd;
          m_addr[c]        = m_addr[c] + 8'd1;
        end
      end
      dc_pkg::OP_SETFZ: begin
        m_addr[c] = t;
        m_dir[c]  = 1'b0;
        m_mod[c]  = 1'b1;
      end
      dc_pkg::OP_SETBZ: begin
        m_addr[c] = t;
        m_dir[c]  = 1'b1;
        m_mod[c]  = 1'b1;
      end
      default: begin
        if (ji) begin
          sel       = 2'd0;
          m_addr[0] = m_addr[0] + 8'd1;
        end else begin
          reload = 1'b0;
        end
      end
    endcase
    if (reload) m_val[sel] = m_mem[m_addr[sel]];
  endtask

  task automatic issue_instruction(input logic [5:0] op, input logic [1:0] c, input logic ji,
                                   input logic [7:0] t, input logic [15:0] wd);
    logic reload_exp;
    @(posedge clk);
    instr_strobe   <= 1'b1;
    instruction    <= {op, c};
    jump_immediate <= ji;
    top            <= t;
    write_data     <= wd;
    @(posedge clk); // accepted here, busy is low.
    instr_strobe   <= 1'b0;
    model_apply(op, c, ji, t, wd, reload_exp);
    @(negedge clk);
    if (busy !== reload_exp) begin
      if (reload_exp) $display("busy did not rise after an instruction that reloads");
      else $display("busy rose for an instruction that reloads nothing");
      report_failure();
    end
    while (busy) @(negedge clk);
    check_state(state, expected_state());
    check_values(values, expected_values());
  endtask

  initial begin
    logic [31:0] r;
    logic [5:0]  op;
    logic [1:0]  c;
    logic        ji;
    logic [7:0]  t;
    logic [15:0] wd;
    rst_n          = 1'b0;
    instr_strobe   = 1'b0;
    instruction    = 8'h00;
    jump_immediate = 1'b0;
    top            = '0;
    write_data     = '0;
    lfsr           = 16'd14963;
    for (int i = 0; i < `DC_MEM_DEPTH; i++) m_mem[i] = '0;
    for (int i = 0; i < 4; i++) begin
      m_addr[i] = '0;
      m_val[i]  = '0;
    end
    m_dir = 4'h0;
    m_mod = 4'h0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_state(state, expected_state());
    check_values(values, expected_values());

    issue_instruction(dc_pkg::OP_SETFZ, 2'd1, 1'b0, 8'h10, 16'h0000);
    issue_instruction(dc_pkg::OP_WRITEZ, 2'd1, 1'b0, 8'h00, 16'hBEEF); // forward write.
    issue_instruction(dc_pkg::OP_SETBZ, 2'd2, 1'b0, 8'h20, 16'h0000);
    issue_instruction(dc_pkg::OP_WRITEZ, 2'd2, 1'b0, 8'h00, 16'h1234); // backward write.
    issue_instruction(dc_pkg::OP_SETFZ, 2'd3, 1'b0, 8'h10, 16'h0000);
    issue_instruction(dc_pkg::OP_SETFZ, 2'd0, 1'b0, 8'h0F, 16'h0000);
    issue_instruction(dc_pkg::OP_READZ, 2'd0, 1'b0, 8'h00, 16'h0000);
    issue_instruction(6'h3F, 2'd2, 1'b1, 8'h00, 16'h0000); // implicit read on cursor 0.
    issue_instruction(dc_pkg::OP_SETFZ, 2'd1, 1'b0, 8'hFF, 16'h0000);
    issue_instruction(dc_pkg::OP_READZ, 2'd1, 1'b0, 8'h00, 16'h0000); // wraps to 0.
    issue_instruction(dc_pkg::OP_SETBZ, 2'd3, 1'b0, 8'h00, 16'h0000);
    issue_instruction(dc_pkg::OP_WRITEZ, 2'd3, 1'b0, 8'h00, 16'hA5A5);
    issue_instruction(dc_pkg::OP_SETFZ, 2'd2, 1'b0, 8'h1F, 16'h0000);
    issue_instruction(6'h20, 2'd2, 1'b0, 8'h55, 16'h7777);
    issue_instruction(6'h00, 2'd3, 1'b0, 8'hAA, 16'h8888);
    issue_instruction(dc_pkg::OP_READZ, 2'd3, 1'b0, 8'h00, 16'h0000);

    for (int n = 0; n < num_random; n++) begin
      r = rand_bits(3);
      case (r[2:0])
        3'd0, 3'd1: op = dc_pkg::OP_READZ;
        3'd2, 3'd3: op = dc_pkg::OP_WRITEZ;
        3'd4:       op = dc_pkg::OP_SETFZ;
        3'd5:       op = dc_pkg::OP_SETBZ;
        default: begin
          r  = rand_bits(6);
          op = r[5:0];
          if (op >= 6'd1 && op <= 6'd4) op = op + 6'd40; // keep it a non-cursor code.
        end
      endcase
      r  = rand_bits(2);
      c  = r[1:0];
      r  = rand_bits(1);
      ji = r[0];
      r  = rand_bits(8);
      t  = r[7:0];
      r  = rand_bits(16);
      wd = r[15:0];
      issue_instruction(op, c, ji, t, wd);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- dc_unit.f
+incdir+common
common/dc_pkg.sv
dc/dc_control.sv
dc/dc_state.sv
dc/dc_prefetch.sv
dc/dc_writer.sv
verilog/mem_arbiter.sv
verilog/main_ram.sv
verilog/dc_unit.sv
tb/dc_unit_assert.sv
tb/dc_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dc_unit testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module dc_unit_tb -f dc_unit.f \
  --Mdir "$OBJ" -o dc_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/dc_unit_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG"
exit 1
